/* Makefile */
BIN  := obj_dir/Vmem3r3w_tb
SRCS := $(shell cat list.f)

.PHONY: run clean

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" sim.log || { echo "simulation ended without a result"; exit 1; }

# rebuilt only when the file list or one of its sources changes.
$(BIN): list.f $(SRCS)
	verilator --binary --timing --assert --top-module mem3r3w_tb -f list.f -o Vmem3r3w_tb

clean:
	rm -rf obj_dir sim.log

/* list.f */
logic/mem3r3w_pkg.sv
logic/mem3r3w_wrap.sv
logic/mem3r3w_array.sv
logic/mem3r3w_top.sv
sim/mem3r3w_props.sv
sim/mem3r3w_tb.sv

/* logic/mem3r3w_array.sv */
`timescale 1ns/10ps

module mem3r3w_array import mem3r3w_pkg::*; #(
  parameter int T1_DELAY = 1
) (
  input  logic    clk,

  // read ports.
  input  rd_vec_t mem_read,
  input  addr_t   mem_rd_adr [NUM_RD],

  // write ports, each with a per-bit write mask.
  input  wr_vec_t mem_write,
  input  addr_t   mem_wr_adr [NUM_WR],
  input  data_t   mem_din [NUM_WR],
  input  data_t   mem_bw [NUM_WR],

  output data_t   mem_dout [NUM_RD]
);

  data_t mem [NUM_ADDR];

  data_t rd_word [NUM_RD];  // current contents at each read address.

  //////////////////////////////////////////////////////////////////////
  // writes
  //////////////////////////////////////////////////////////////////////

  // ports are walked in ascending order and each bit is its own
  // nonblocking update, so the last port to touch a bit owns it.
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_WR; p++) begin
      if (mem_write[p]) begin
        for (int b = 0; b < DATA_W; b++) begin
          if (mem_bw[p][b]) begin
            mem[mem_wr_adr[p]][b] <= mem_din[p][b];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reads
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_word[p] = mem[mem_rd_adr[p]];  // old word until the edge.
    end
  end

  if (T1_DELAY > 0) begin : g_rd_flop

    data_t rd_pipe [T1_DELAY][NUM_RD];

    always_ff @(posedge clk) begin
      for (int p = 0; p < NUM_RD; p++) begin
        if (mem_read[p]) begin
          rd_pipe[0][p] <= rd_word[p];  // sampled before this edge's writes land.
        end
      end
      for (int s = 1; s < T1_DELAY; s++) begin
        for (int p = 0; p < NUM_RD; p++) begin
          rd_pipe[s][p] <= rd_pipe[s-1][p];
        end
      end
    end

    always_comb begin
      for (int p = 0; p < NUM_RD; p++) begin
        mem_dout[p] = rd_pipe[T1_DELAY-1][p];
      end
    end

  end else begin : g_rd_comb

    // zero latency: data flows straight from the array in the same
    // cycle, and an idle port reads as zero.
    always_comb begin
      for (int p = 0; p < NUM_RD; p++) begin
        mem_dout[p] = mem_read[p] ? rd_word[p] : '0;
      end
    end

  end

endmodule

/* logic/mem3r3w_pkg.sv */
package mem3r3w_pkg;

  //////////////////////////////////////////////////////////////////////
  // port counts and geometry
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_RD   = 3;   // read ports.
  localparam int NUM_WR   = 3;   // write ports.
  localparam int DATA_W   = 16;  // bits per word.
  localparam int ADDR_W   = 8;   // word address width.
  localparam int NUM_ADDR = 256; // words in the array, 2**ADDR_W.

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  // write data, bit-write mask and read data all share this width.
  typedef logic [DATA_W-1:0] data_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // one enable or valid bit per read port, bit 0 is port 0.
  typedef logic [NUM_RD-1:0] rd_vec_t;

  // one enable bit per write port.
  typedef logic [NUM_WR-1:0] wr_vec_t;

endpackage

/* logic/mem3r3w_top.sv */
`timescale 1ns/10ps

module mem3r3w_top import mem3r3w_pkg::*; #(
  parameter int FLOPIN   = 1,
  parameter int T1_DELAY = 1,
  parameter int FLOPOUT  = 1
) (
  input  logic    clk,
  input  logic    reset,

  input  rd_vec_t read,
  input  addr_t   rd_adr [NUM_RD],
  output data_t   rd_dout [NUM_RD],
  output rd_vec_t rd_vld,

  input  wr_vec_t write,
  input  addr_t   wr_adr [NUM_WR],
  input  data_t   din [NUM_WR],
  input  data_t   bw [NUM_WR]
);

  //////////////////////////////////////////////////////////////////////
  // wrapper to array
  //////////////////////////////////////////////////////////////////////

  rd_vec_t mem_read;
  addr_t   mem_rd_adr [NUM_RD];
  wr_vec_t mem_write;
  addr_t   mem_wr_adr [NUM_WR];
  data_t   mem_din [NUM_WR];
  data_t   mem_bw [NUM_WR];
  data_t   mem_dout [NUM_RD];

  // read latency at this level is FLOPIN + T1_DELAY + FLOPOUT.
  mem3r3w_wrap #(
    .FLOPIN   (FLOPIN),
    .T1_DELAY (T1_DELAY),
    .FLOPOUT  (FLOPOUT)
  ) u_wrap (
    .clk        (clk),
    .reset      (reset),
    .read       (read),
    .rd_adr     (rd_adr),
    .rd_dout    (rd_dout),
    .rd_vld     (rd_vld),
    .write      (write),
    .wr_adr     (wr_adr),
    .din        (din),
    .bw         (bw),
    .mem_read   (mem_read),
    .mem_rd_adr (mem_rd_adr),
    .mem_write  (mem_write),
    .mem_wr_adr (mem_wr_adr),
    .mem_din    (mem_din),
    .mem_bw     (mem_bw),
    .mem_dout   (mem_dout)
  );

  mem3r3w_array #(
    .T1_DELAY (T1_DELAY)
  ) u_array (
    .clk        (clk),
    .mem_read   (mem_read),
    .mem_rd_adr (mem_rd_adr),
    .mem_write  (mem_write),
    .mem_wr_adr (mem_wr_adr),
    .mem_din    (mem_din),
    .mem_bw     (mem_bw),
    .mem_dout   (mem_dout)
  );

endmodule

/* logic/mem3r3w_wrap.sv */
`timescale 1ns/10ps

module mem3r3w_wrap import mem3r3w_pkg::*; #(
  parameter int FLOPIN   = 1,
  parameter int T1_DELAY = 1,
  parameter int FLOPOUT  = 1
) (
  input  logic    clk,
  input  logic    reset,

  // external read side.
  input  rd_vec_t read,
  input  addr_t   rd_adr [NUM_RD],
  output data_t   rd_dout [NUM_RD],
  output rd_vec_t rd_vld,

  // external write side.
  input  wr_vec_t write,
  input  addr_t   wr_adr [NUM_WR],
  input  data_t   din [NUM_WR],
  input  data_t   bw [NUM_WR],

  // per-port signals to the storage array.
  output rd_vec_t mem_read,
  output addr_t   mem_rd_adr [NUM_RD],
  output wr_vec_t mem_write,
  output addr_t   mem_wr_adr [NUM_WR],
  output data_t   mem_din [NUM_WR],
  output data_t   mem_bw [NUM_WR],
  input  data_t   mem_dout [NUM_RD]
);

  // the array adds T1_DELAY and the output flops add FLOPOUT on top of
  // the command path, so valid has to ride along for both.
  localparam int VLD_STAGES = T1_DELAY + FLOPOUT;

  //////////////////////////////////////////////////////////////////////
  // command path
  //////////////////////////////////////////////////////////////////////

  if (FLOPIN > 0) begin : g_flopin

    always_ff @(posedge clk) begin
      if (reset) begin
        mem_read  <= '0;
        mem_write <= '0;
      end else begin
        mem_read  <= read;
        mem_write <= write;
      end
    end

    always_ff @(posedge clk) begin
      for (int p = 0; p < NUM_RD; p++) begin
        mem_rd_adr[p] <= rd_adr[p];
      end
      for (int p = 0; p < NUM_WR; p++) begin
        mem_wr_adr[p] <= wr_adr[p];
        mem_din[p]    <= din[p];
        mem_bw[p]     <= bw[p];  // mask travels with its data.
      end
    end

  end else begin : g_no_flopin

    always_comb begin
      mem_read  = read;
      mem_write = write;
      for (int p = 0; p < NUM_RD; p++) begin
        mem_rd_adr[p] = rd_adr[p];
      end
      for (int p = 0; p < NUM_WR; p++) begin
        mem_wr_adr[p] = wr_adr[p];
        mem_din[p]    = din[p];
        mem_bw[p]     = bw[p];
      end
    end

  end

  //////////////////////////////////////////////////////////////////////
  // read-valid delay line
  //////////////////////////////////////////////////////////////////////

  if (VLD_STAGES > 0) begin : g_vld_line

    rd_vec_t vld_pipe [VLD_STAGES];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int s = 0; s < VLD_STAGES; s++) begin
          vld_pipe[s] <= '0;
        end
      end else begin
        vld_pipe[0] <= mem_read; // enters as the array sees the read.
        for (int s = 1; s < VLD_STAGES; s++) begin
          vld_pipe[s] <= vld_pipe[s-1];
        end
      end
    end

    assign rd_vld = vld_pipe[VLD_STAGES-1];

  end else begin : g_vld_pass

    // combinational array and no output flops.
    assign rd_vld = mem_read;

  end

  //////////////////////////////////////////////////////////////////////
  // read data output stages
  //////////////////////////////////////////////////////////////////////

  if (FLOPOUT > 0) begin : g_dout_line

    // every stage shifts each cycle, so a new read can enter behind
    // one that is still on its way out.
    data_t dout_pipe [FLOPOUT][NUM_RD];

    always_ff @(posedge clk) begin
      for (int p = 0; p < NUM_RD; p++) begin
        dout_pipe[0][p] <= mem_dout[p];
      end
      for (int s = 1; s < FLOPOUT; s++) begin
        for (int p = 0; p < NUM_RD; p++) begin
          dout_pipe[s][p] <= dout_pipe[s-1][p];
        end
      end
    end

    always_comb begin
      for (int p = 0; p < NUM_RD; p++) begin
        rd_dout[p] = dout_pipe[FLOPOUT-1][p];
      end
    end

  end else begin : g_dout_pass

    always_comb begin
      for (int p = 0; p < NUM_RD; p++) begin
        rd_dout[p] = mem_dout[p];
      end
    end

  end

endmodule

/* sim/mem3r3w_props.sv */
`timescale 1ns/10ps

module mem3r3w_props import mem3r3w_pkg::*; #(
  parameter int LATENCY = 3
) (
  input logic    clk,
  input logic    reset,
  input rd_vec_t read,
  input rd_vec_t rd_vld
);

  int filled;  // cycles since reset, saturates at LATENCY.

  always_ff @(posedge clk) begin
    if (reset) begin
      filled <= 0;
    end else if (filled < LATENCY) begin
      filled <= filled + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // valid timing
  //////////////////////////////////////////////////////////////////////

  a_vld_follows_read: assert property (@(posedge clk) disable iff (reset)
    filled == LATENCY |-> rd_vld == $past(read, LATENCY))
    else $error("rd_vld %b is not the read vector of %0d cycles back", rd_vld, LATENCY);

  a_vld_low_in_reset: assert property (@(posedge clk)
    reset |=> rd_vld == '0)
    else $error("rd_vld %b high right after a reset cycle", rd_vld);

  // nothing issued after reset can have come out yet.
  a_vld_low_filling: assert property (@(posedge clk) disable iff (reset)
    filled < LATENCY |-> rd_vld == '0)
    else $error("rd_vld %b high before the read pipeline filled", rd_vld);

  a_vld_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(rd_vld))
    else $error("rd_vld has unknown bits");

endmodule

/* sim/mem3r3w_tb.sv */
`timescale 1ns/10ps

module mem3r3w_tb import mem3r3w_pkg::*; ();

  localparam int FLOPIN      = 1;
  localparam int T1_DELAY    = 1;
  localparam int FLOPOUT     = 1;
  localparam int LATENCY     = FLOPIN + T1_DELAY + FLOPOUT;
  localparam int TIMEOUT     = 50;   // cycles any wait may take.
  localparam int RAND_CYCLES = 400;

  logic    clk;
  logic    reset;
  rd_vec_t read;
  addr_t   rd_adr [NUM_RD];
  data_t   rd_dout [NUM_RD];
  rd_vec_t rd_vld;
  wr_vec_t write;
  addr_t   wr_adr [NUM_WR];
  data_t   din [NUM_WR];
  data_t   bw [NUM_WR];

  // commands a test has set up for the next cycle.
  rd_vec_t nxt_read;
  addr_t   nxt_rd_adr [NUM_RD];
  wr_vec_t nxt_write;
  addr_t   nxt_wr_adr [NUM_WR];
  data_t   nxt_din [NUM_WR];
  data_t   nxt_bw [NUM_WR];

  data_t   shadow [NUM_ADDR];
  data_t   exp_q [NUM_RD][$];  // expected words in issue order, per port.
  rd_vec_t rd_hist [$];
  logic    checking = 1'b0;
  int      cmp_errors = 0;
  int      seq_errors = 0;
  int      checks = 0;

  mem3r3w_top #(
    .FLOPIN   (FLOPIN),
    .T1_DELAY (T1_DELAY),
    .FLOPOUT  (FLOPOUT)
  ) u_mem3r3w_top (
    .clk     (clk),
    .reset   (reset),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw)
  );

  bind mem3r3w_top mem3r3w_props #(
    .LATENCY (FLOPIN + T1_DELAY + FLOPOUT)
  ) u_props (
    .clk    (clk),
    .reset  (reset),
    .read   (read),
    .rd_vld (rd_vld)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic data_t merge_bits(data_t old_word, data_t new_word, data_t mask);
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // a read sees the shadow as it was before this cycle's writes.
  function automatic data_t expected_word(addr_t a);
    return shadow[a];
  endfunction

  function automatic data_t fill_word(addr_t a);
    return {a, ~a} ^ 16'h5a3c;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int p = 0; p < NUM_RD; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  function automatic int total_errors();
    return cmp_errors + seq_errors;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_data(input int port, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      cmp_errors++;
      $display("mismatch at %0t: port %0d read data %h, expected %h", $time, port, got, exp);
    end
  endtask

  task automatic check_valid(input rd_vec_t got, input rd_vec_t exp);
    checks++;
    if (got !== exp) begin
      cmp_errors++;
      $display("mismatch at %0t: rd_vld %b, expected %b", $time, got, exp);
    end
  endtask

  always @(negedge clk) begin
    rd_vec_t exp_vld;
    if (checking) begin
      rd_hist.push_back(read);
      exp_vld = '0;
      if (rd_hist.size() > LATENCY) begin
        exp_vld = rd_hist.pop_front();
      end
      check_valid(rd_vld, exp_vld);
      for (int p = 0; p < NUM_RD; p++) begin
        if (rd_vld[p] === 1'b1) begin
          if (exp_q[p].size() == 0) begin
            cmp_errors++;
            $display("port %0d raised read valid at %0t with no read outstanding", p, $time);
          end else begin
            check_data(p, rd_dout[p], exp_q[p].pop_front());
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic stage_read(input int p, input addr_t a);
    nxt_read[p]   = 1'b1;
    nxt_rd_adr[p] = a;
  endtask

  task automatic stage_write(input int p, input addr_t a, input data_t d, input data_t m);
    nxt_write[p]  = 1'b1;
    nxt_wr_adr[p] = a;
    nxt_din[p]    = d;
    nxt_bw[p]     = m;
  endtask

  task automatic issue_cycle();
    for (int p = 0; p < NUM_RD; p++) begin
      if (nxt_read[p]) begin
        exp_q[p].push_back(expected_word(nxt_rd_adr[p]));
      end
    end
    for (int p = 0; p < NUM_WR; p++) begin  // port order sets the winner.
      if (nxt_write[p]) begin
        shadow[nxt_wr_adr[p]] = merge_bits(shadow[nxt_wr_adr[p]], nxt_din[p], nxt_bw[p]);
      end
    end
    @(posedge clk);
    read  <= nxt_read;
    write <= nxt_write;
    for (int p = 0; p < NUM_RD; p++) begin
      rd_adr[p] <= nxt_rd_adr[p];
    end
    for (int p = 0; p < NUM_WR; p++) begin
      wr_adr[p] <= nxt_wr_adr[p];
      din[p]    <= nxt_din[p];
      bw[p]     <= nxt_bw[p];
    end
    nxt_read  = '0;
    nxt_write = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) issue_cycle();
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (outstanding() != 0 && waited < TIMEOUT) begin
      issue_cycle();
      waited++;
    end
    if (outstanding() != 0) begin
      seq_errors++;
      $display("read valid never came for %0d outstanding reads by %0t", outstanding(), $time);
    end
    idle_cycles(2);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic latency_after_reset();
    int waited;
    logic seen;
    idle_cycles(5);
    stage_write(0, 8'h10, 16'h1234, 16'hffff);
    issue_cycle();
    stage_read(0, 8'h10);
    issue_cycle();
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < TIMEOUT) begin
      @(negedge clk);
      if (rd_vld[0] === 1'b1) begin
        seen = 1'b1;
      end else begin
        issue_cycle();
        waited++;
      end
    end
    if (!seen) begin
      seq_errors++;
      $display("read valid never came on port 0 after the first read");
    end else if (waited != LATENCY) begin
      seq_errors++;
      $display("mismatch at %0t: read valid after %0d cycles, expected %0d",
               $time, waited, LATENCY);
    end
    drain_reads();
  endtask

  task automatic full_word_traffic();
    for (int i = 0; i < 8; i++) begin
      for (int p = 0; p < NUM_WR; p++) begin
        stage_write(p, addr_t'(8'h20 + 3 * i + p), fill_word(addr_t'(8'h20 + 3 * i + p)),
                    16'hffff);
      end
      issue_cycle();
    end
    // each port reads back a word another port wrote.
    for (int i = 0; i < 8; i++) begin
      for (int p = 0; p < NUM_RD; p++) begin
        stage_read(p, addr_t'(8'h20 + 3 * i + (p + 1) % NUM_WR));
      end
      issue_cycle();
    end
    drain_reads();
  endtask

  task automatic masked_writes();
    stage_write(0, 8'h40, 16'h0000, 16'hffff);
    issue_cycle();
    stage_write(1, 8'h40, 16'hffff, 16'h00f0);
    issue_cycle();
    stage_write(2, 8'h40, 16'h1234, 16'hff00);
    issue_cycle();
    for (int p = 0; p < NUM_RD; p++) begin
      stage_read(p, 8'h40);
    end
    issue_cycle();
    // the rest of the window starts from known words.
    for (int i = 1; i < 8; i++) begin
      stage_write(i % NUM_WR, addr_t'(8'h40 + i), fill_word(addr_t'(8'h40 + i)), 16'hffff);
      issue_cycle();
    end
    for (int i = 0; i < 16; i++) begin
      stage_write(i % NUM_WR, addr_t'(8'h40 + i % 8), data_t'($urandom), data_t'($urandom));
      stage_read(i % NUM_RD, addr_t'(8'h40 + (i + 3) % 8));
      issue_cycle();
    end
    drain_reads();
  endtask

  task automatic port_collisions();
    stage_write(0, 8'h50, 16'haaaa, 16'hffff);
    stage_write(1, 8'h51, 16'h5555, 16'hffff);
    issue_cycle();
    stage_write(0, 8'h50, 16'h1111, 16'hffff);
    stage_write(1, 8'h50, 16'h2222, 16'h0ff0);
    stage_write(2, 8'h50, 16'h3333, 16'h00ff);
    issue_cycle();
    stage_write(0, 8'h51, 16'hc3c3, 16'hff0f);
    stage_write(2, 8'h51, 16'h7e7e, 16'h0ff0);
    stage_read(0, 8'h50);
    issue_cycle();
    stage_read(1, 8'h50);
    stage_read(2, 8'h51);
    issue_cycle();
    drain_reads();
  endtask

  task automatic read_during_write();
    stage_write(0, 8'h60, 16'h0f0f, 16'hffff);
    issue_cycle();
    stage_write(1, 8'h60, 16'hbeef, 16'hffff);
    stage_read(0, 8'h60);  // same cycle, so still the old word.
    issue_cycle();
    stage_read(2, 8'h60);
    issue_cycle();
    drain_reads();
  endtask

  task automatic random_traffic();
    addr_t a;
    for (int base = 0; base < NUM_ADDR; base += NUM_WR) begin
      for (int p = 0; p < NUM_WR; p++) begin
        if (base + p < NUM_ADDR) begin
          stage_write(p, addr_t'(base + p), fill_word(addr_t'(base + p)), 16'hffff);
        end
      end
      issue_cycle();
    end
    for (int c = 0; c < RAND_CYCLES; c++) begin
      for (int p = 0; p < NUM_WR; p++) begin
        a = addr_t'($urandom);
        if ($urandom_range(0, 1) == 1) begin
          a = a & 8'h07;  // crowd half the traffic onto a few words.
        end
        stage_write(p, a, data_t'($urandom), data_t'($urandom));
      end
      for (int p = 0; p < NUM_RD; p++) begin
        a = addr_t'($urandom);
        if ($urandom_range(0, 1) == 1) begin
          a = a & 8'h07;
        end
        stage_read(p, a);
      end
      issue_cycle();
    end
    drain_reads();
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%-20s done with %0d errors", name, total_errors() - errors_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int start;
    void'($urandom(58));
    reset     = 1'b1;
    read      = '0;
    write     = '0;
    nxt_read  = '0;
    nxt_write = '0;
    for (int p = 0; p < NUM_RD; p++) begin
      rd_adr[p]     = '0;
      nxt_rd_adr[p] = '0;
    end
    for (int p = 0; p < NUM_WR; p++) begin
      wr_adr[p]     = '0;
      din[p]        = '0;
      bw[p]         = '0;
      nxt_wr_adr[p] = '0;
      nxt_din[p]    = '0;
      nxt_bw[p]     = '0;
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    checking = 1'b1;

    start = total_errors();
    latency_after_reset();
    report_test("latency_after_reset", start);
    start = total_errors();
    full_word_traffic();
    report_test("full_word_traffic", start);
    start = total_errors();
    masked_writes();
    report_test("masked_writes", start);
    start = total_errors();
    port_collisions();
    report_test("port_collisions", start);
    start = total_errors();
    read_during_write();
    report_test("read_during_write", start);
    start = total_errors();
    random_traffic();
    report_test("random_traffic", start);

    $display("%0d checks, %0d errors", checks, total_errors());
    if (total_errors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
